/* uram_event_chbuffer.f */
hw/ev_pkg.sv
hw/ev_write_sequencer.sv
hw/ev_lane_packer.sv
hw/ev_bank_ram.sv
hw/ev_bank_array.sv
hw/uram_event_chbuffer.sv
tb/ev_checker.sv
tb/tb_uram_event_chbuffer.sv

/* Bender.yml */
package:
  name: uram_event_chbuffer

sources:
  - files:
      - hw/ev_pkg.sv
      - hw/ev_write_sequencer.sv
      - hw/ev_lane_packer.sv
      - hw/ev_bank_ram.sv
      - hw/ev_bank_array.sv
      - hw/uram_event_chbuffer.sv
  - target: test
    files:
      - tb/ev_checker.sv
      - tb/tb_uram_event_chbuffer.sv

/* tb/tb_uram_event_chbuffer.sv */
`timescale 1ns/1ps
module tb_uram_event_chbuffer;
    import ev_pkg::*;

    localparam int RUN_DELAY = 3;
    localparam logic [47:0] ORDER_DEF = "FEDCBA";
    localparam logic [47:0] ORDER_ALT = "FCEDBA";
    localparam int NUM_BURSTS = 8;
    localparam int NUM_READS = 40;
    // upper bounds, a burst has up to 4 groups and a read may get an idle cycle
    localparam int MAX_BEATS = 4 + 16 * NUM_BURSTS;
    localparam int MAX_READS = 36 + 16 + 2 * NUM_READS * NUM_BURSTS;
    localparam int WATCHDOG_NS = (MAX_BEATS + MAX_READS + 64 * (NUM_BURSTS + 1)) * 100 * 2;

    logic                     memclk_i = 1'b0;
    logic                     reset_laddr_delay_i;
    logic                     channel_run_i;
    logic [UADDR_W-1:0]       bram_uaddr_i;
    beat_t                    dat_i;
    rd_req_t                  rd_i;
    logic [2:0]               test_id_i;
    logic                     uaddr_chk_i;
    logic [UADDR_W-1:0]       exp_uaddr_i;
    // index 0 is the FEDCBA DUT, index 1 the FCEDBA one
    logic [1:0][7:0]          exp_byte;
    logic [1:0][7:0]          dut_byte;
    logic [1:0][UADDR_W-1:0]  dut_uaddr;
    int                       err_cnt [2];
    int                       chk_cnt [2];
    logic [15:0]              lfsr = 16'd31;
    // model memory per order, word then byte n mod 12 of the stream
    logic [7:0]               model_mem [2][2**WADDR_W][BYTES_PER_WORD];
    int                       stream_n;
    logic [UADDR_W-1:0]       cur_uaddr;

    always #50 memclk_i = ~memclk_i;

    uram_event_chbuffer #(.RUN_DELAY(RUN_DELAY), .SAMPLE_ORDER(ORDER_DEF)) u_dut (
        .*, .next_bram_uaddr_o(dut_uaddr[0]), .dat_o(dut_byte[0]));
    uram_event_chbuffer #(.RUN_DELAY(RUN_DELAY), .SAMPLE_ORDER(ORDER_ALT)) u_dut_alt (
        .*, .next_bram_uaddr_o(dut_uaddr[1]), .dat_o(dut_byte[1]));
    ev_checker #(.NAME("order_fedcba")) u_chk (
        .*, .exp_byte_i(exp_byte[0]), .dut_byte_i(dut_byte[0]),
        .dut_uaddr_i(dut_uaddr[0]), .err_cnt_o(err_cnt[0]), .chk_cnt_o(chk_cnt[0]));
    ev_checker #(.NAME("order_fcedba")) u_chk_alt (
        .*, .exp_byte_i(exp_byte[1]), .dut_byte_i(dut_byte[1]),
        .dut_uaddr_i(dut_uaddr[1]), .err_cnt_o(err_cnt[1]), .chk_cnt_o(chk_cnt[1]));

    // fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic beat_t random_beat();
        beat_t b;
        b[31:0] = rand_bits(32);
        b[63:32] = rand_bits(32);
        b[71:64] = 8'(rand_bits(8));
        return b;
    endfunction

    // output nybble i takes input nybble (letter i - 'A'), letters counted from the right
    function automatic logic [23:0] reorder_chunk(input logic [23:0] c, input logic [47:0] order);
        logic [23:0] r;
        int src;
        for (int i = 0; i < 6; i++) begin
            src = int'(order[8*i +: 8]) - 65;
            r[4*i +: 4] = c[4*src +: 4];
        end
        return r;
    endfunction

    function automatic int word_of(input logic [UADDR_W-1:0] ua, input int k);
        return (int'(ua) * 4 + k) % (2**WADDR_W);
    endfunction

    // chunks in arrival order form the byte stream, low byte first
    task automatic model_append(input beat_t b);
        logic [23:0] ch;
        int n;
        for (int o = 0; o < 2; o++) begin
            for (int c = 0; c < 3; c++) begin
                ch = reorder_chunk(b[24*c +: 24], (o == 0) ? ORDER_DEF : ORDER_ALT);
                for (int k = 0; k < 3; k++) begin
                    n = stream_n + 3 * c + k;
                    model_mem[o][word_of(cur_uaddr, n / 12)][n % 12] = ch[8*k +: 8];
                end
            end
        end
        stream_n += 9;
    endtask

    task automatic run_burst(input logic [UADDR_W-1:0] ua, input int groups);
        uaddr_chk_i = 1'b0;
        stream_n = 0;
        cur_uaddr = ua;
        bram_uaddr_i = ua;
        // beat j meets the delayed run RUN_DELAY edges after the run level
        for (int j = 0; j < 4 * groups + RUN_DELAY; j++) begin
            @(negedge memclk_i);
            channel_run_i = (j < 4 * groups);
            // uaddr moves after the start edge, only the captured one counts
            if (j == RUN_DELAY + 1) begin
                bram_uaddr_i = ~ua;
            end
            if (j >= RUN_DELAY) begin
                dat_i = random_beat();
                model_append(dat_i);
            end
        end
        repeat (8) @(negedge memclk_i);
        exp_uaddr_i = ua;
        uaddr_chk_i = 1'b1;
    endtask

    task automatic read_byte(input int word, input int bank, input int lane);
        @(negedge memclk_i);
        rd_i.sel = 3'(1 << bank);
        rd_i.raddr = RADDR_W'(word * 4 + lane);
        for (int o = 0; o < 2; o++) begin
            exp_byte[o] = model_mem[o][word][4 * bank + lane];
        end
    endtask

    // no bank bit, raddr is noise
    task automatic idle_reads(input int n);
        repeat (n) begin
            @(negedge memclk_i);
            rd_i.sel = '0;
            rd_i.raddr = RADDR_W'(rand_bits(RADDR_W));
        end
    endtask

    initial begin : main
        logic [UADDR_W-1:0] ua;
        int groups;
        int w;
        int bk;
        int ln;
        reset_laddr_delay_i = 1'b1;
        channel_run_i = 1'b0;
        bram_uaddr_i = '0;
        dat_i = '0;
        rd_i = '0;
        exp_byte = '0;
        exp_uaddr_i = '0;
        uaddr_chk_i = 1'b0;
        test_id_i = 3'd1;
        stream_n = 0;
        cur_uaddr = '0;
        repeat (2) @(negedge memclk_i);
        reset_laddr_delay_i = 1'b0;
        uaddr_chk_i = 1'b1;
        idle_reads(4);

        // one group, every stream byte in order
        test_id_i = 3'd2;
        ua = 8'h05;
        run_burst(ua, 1);
        for (int n = 0; n < 36; n++) begin
            read_byte(word_of(ua, n / 12), (n % 12) / 4, n % 4);
        end
        idle_reads(3);

        test_id_i = 3'd3;
        for (int b = 0; b < NUM_BURSTS; b++) begin
            ua = UADDR_W'(rand_bits(UADDR_W));
            groups = 1 + int'(rand_bits(2));
            run_burst(ua, groups);
            for (int r = 0; r < NUM_READS; r++) begin
                w = word_of(ua, int'(rand_bits(4)) % (3 * groups));
                bk = int'(rand_bits(2)) % 3;
                ln = int'(rand_bits(2));
                read_byte(w, bk, ln);
                if (rand_bits(1) != 0) begin
                    idle_reads(1);
                end
            end
            idle_reads(2);
        end

        // back-to-back across banks, then dat_o must hold
        test_id_i = 3'd4;
        for (int r = 0; r < 6; r++) begin
            read_byte(word_of(ua, r % 3), r % 3, r % 4);
        end
        idle_reads(5);
        read_byte(word_of(ua, 0), 2, 3);
        idle_reads(5);

        $display("closing: errors %0d + %0d, checks %0d + %0d",
                 err_cnt[0], err_cnt[1], chk_cnt[0], chk_cnt[1]);
        if (err_cnt[0] + err_cnt[1] == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* tb/ev_checker.sv */
`timescale 1ns/1ps
module ev_checker #(
    parameter string NAME = "dut"
) (
    input  logic                        memclk_i,
    input  logic                        reset_laddr_delay_i,
    input  logic [2:0]                  test_id_i,
    input  ev_pkg::rd_req_t             rd_i,
    // expected byte travels next to its request
    input  logic [7:0]                  exp_byte_i,
    input  logic [7:0]                  dut_byte_i,
    input  logic                        uaddr_chk_i,
    input  logic [ev_pkg::UADDR_W-1:0]  exp_uaddr_i,
    input  logic [ev_pkg::UADDR_W-1:0]  dut_uaddr_i,
    output int                          err_cnt_o,
    output int                          chk_cnt_o
);
    import ev_pkg::*;

    // request pipe, bit 1 is due at this edge
    logic [1:0]       vld_q;
    logic [1:0][7:0]  exp_q;
    logic [7:0]       exp_now;
    // dat_o keeps the last byte read
    logic [7:0]       exp_hold;
    int               err_cnt = 0;
    int               chk_cnt = 0;

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1: return "reset_state";
            3'd2: return "fixed_burst";
            3'd3: return "random_bursts";
            default: return "read_timing";
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s %s %s: expected %0h actual %0h",
                     NAME, test_label(test_id_i), what, exp, act);
        end
    endtask

    // outputs read here still hold the values of the previous edge
    always @(posedge memclk_i) begin
        if (reset_laddr_delay_i) begin
            vld_q    <= '0;
            exp_hold = 8'h00;
        end else begin
            exp_now = vld_q[1] ? exp_q[1] : exp_hold;
            compare("dat_o", exp_now, dut_byte_i);
            exp_hold = exp_now;
            if (uaddr_chk_i) begin
                compare("next_bram_uaddr_o", exp_uaddr_i, dut_uaddr_i);
            end
            vld_q <= {vld_q[0], rd_i.sel != '0};
            exp_q <= {exp_q[0], exp_byte_i};
        end
    end

endmodule

/* hw/uram_event_chbuffer.sv */
`timescale 1ns/1ps
module uram_event_chbuffer #(
    parameter int          RUN_DELAY    = 0,
    parameter logic [47:0] SAMPLE_ORDER = ev_pkg::DEF_SAMPLE_ORDER
) (
    input  logic                        memclk_i,
    input  logic                        reset_laddr_delay_i,
    // write side
    input  logic                        channel_run_i,
    input  logic [ev_pkg::UADDR_W-1:0]  bram_uaddr_i,
    output logic [ev_pkg::UADDR_W-1:0]  next_bram_uaddr_o,
    input  ev_pkg::beat_t               dat_i,
    // read side, one byte per request
    input  ev_pkg::rd_req_t             rd_i,
    output logic [7:0]                  dat_o
);
    import ev_pkg::*;

    phase_t              phase;
    logic [WADDR_W-1:0]  waddr;
    logic                wr_en;
    bank_wr_set_t        bank_wr;

    // run delay, phase tracking and addressing
    ev_write_sequencer #(
        .RUN_DELAY (RUN_DELAY)
    ) u_seq (
        .memclk_i            (memclk_i),
        .reset_laddr_delay_i (reset_laddr_delay_i),
        .channel_run_i       (channel_run_i),
        .bram_uaddr_i        (bram_uaddr_i),
        .phase_o             (phase),
        .waddr_o             (waddr),
        .wr_en_o             (wr_en),
        .uaddr_o             (next_bram_uaddr_o)
    );

    // nybble reorder and bank steering
    ev_lane_packer #(
        .SAMPLE_ORDER (SAMPLE_ORDER)
    ) u_pack (
        .memclk_i            (memclk_i),
        .reset_laddr_delay_i (reset_laddr_delay_i),
        .dat_i               (dat_i),
        .phase_i             (phase),
        .waddr_i             (waddr),
        .wr_en_i             (wr_en),
        .wr_o                (bank_wr)
    );

    ev_bank_array u_banks (
        .memclk_i            (memclk_i),
        .reset_laddr_delay_i (reset_laddr_delay_i),
        .wr_i                (bank_wr),
        .rd_i                (rd_i),
        .dat_o               (dat_o)
    );

endmodule

/* hw/ev_bank_array.sv */
`timescale 1ns/1ps
module ev_bank_array (
    input  logic                  memclk_i,
    input  logic                  reset_laddr_delay_i,
    input  ev_pkg::bank_wr_set_t  wr_i,
    input  ev_pkg::rd_req_t       rd_i,
    output logic [7:0]            dat_o
);
    import ev_pkg::*;

    logic [NUM_BANKS-1:0][7:0]  bank_byte;
    // select follows the two read stages
    logic [NUM_BANKS-1:0]       sel_d1_q;
    logic [NUM_BANKS-1:0]       sel_last_q;

    ev_bank_ram u_bank_a (
        .memclk_i            (memclk_i),
        .reset_laddr_delay_i (reset_laddr_delay_i),
        .wr_i                (wr_i.a),
        .rd_en_i             (rd_i.sel[0]),
        .raddr_i             (rd_i.raddr),
        .byte_o              (bank_byte[0])
    );

    ev_bank_ram u_bank_b (
        .memclk_i            (memclk_i),
        .reset_laddr_delay_i (reset_laddr_delay_i),
        .wr_i                (wr_i.b),
        .rd_en_i             (rd_i.sel[1]),
        .raddr_i             (rd_i.raddr),
        .byte_o              (bank_byte[1])
    );

    ev_bank_ram u_bank_c (
        .memclk_i            (memclk_i),
        .reset_laddr_delay_i (reset_laddr_delay_i),
        .wr_i                (wr_i.c),
        .rd_en_i             (rd_i.sel[2]),
        .raddr_i             (rd_i.raddr),
        .byte_o              (bank_byte[2])
    );

    // last bank read stays selected so dat_o holds on idle cycles
    always_ff @(posedge memclk_i) begin
        if (reset_laddr_delay_i) begin
            sel_d1_q   <= '0;
            sel_last_q <= '0;
        end else begin
            sel_d1_q <= rd_i.sel;
            if (sel_d1_q != '0) begin
                sel_last_q <= sel_d1_q;
            end
        end
    end

    // one-hot and-or mux
    always_comb begin
        dat_o = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            dat_o |= bank_byte[b] & {8{sel_last_q[b]}};
        end
    end

    a_sel_onehot0 : assert property (
        @(posedge memclk_i) disable iff (reset_laddr_delay_i)
        $onehot0(rd_i.sel)
    );

endmodule

/* hw/ev_bank_ram.sv */
`timescale 1ns/1ps
module ev_bank_ram (
    input  logic                        memclk_i,
    input  logic                        reset_laddr_delay_i,
    input  ev_pkg::bank_wr_t            wr_i,
    input  logic                        rd_en_i,
    input  logic [ev_pkg::RADDR_W-1:0]  raddr_i,
    output logic [7:0]                  byte_o
);
    import ev_pkg::*;

    logic [BANK_W-1:0]   mem [2**WADDR_W];
    // address kept while addr_en is low
    logic [WADDR_W-1:0]  waddr_q;
    logic [WADDR_W-1:0]  waddr;
    logic [BANK_W-1:0]   rd_word_q;
    logic [1:0]          rd_lane_q;
    logic                rd_en_q;

    assign waddr = wr_i.addr_en ? wr_i.addr : waddr_q;

    always_ff @(posedge memclk_i) begin
        if (reset_laddr_delay_i) begin
            waddr_q <= '0;
        end else if (wr_i.addr_en && (wr_i.be != '0)) begin
            waddr_q <= wr_i.addr;
        end
    end

    // byte-enabled write port
    always_ff @(posedge memclk_i) begin
        for (int i = 0; i < BYTES_PER_BANK; i++) begin
            if (wr_i.be[i]) begin
                mem[waddr][8*i +: 8] <= wr_i.data[8*i +: 8];
            end
        end
    end

    // RAM stage, whole word plus the lane to pick later
    always_ff @(posedge memclk_i) begin
        if (rd_en_i) begin
            rd_word_q <= mem[raddr_i[RADDR_W-1:2]];
            rd_lane_q <= raddr_i[1:0];
        end
    end

    // output register, holds between reads
    always_ff @(posedge memclk_i) begin
        if (reset_laddr_delay_i) begin
            rd_en_q <= 1'b0;
            byte_o  <= '0;
        end else begin
            rd_en_q <= rd_en_i;
            if (rd_en_q) begin
                byte_o <= rd_word_q[8*rd_lane_q +: 8];
            end
        end
    end

endmodule

/* hw/ev_lane_packer.sv */
`timescale 1ns/1ps
module ev_lane_packer #(
    parameter logic [47:0] SAMPLE_ORDER = ev_pkg::DEF_SAMPLE_ORDER
) (
    input  logic                        memclk_i,
    input  logic                        reset_laddr_delay_i,
    input  ev_pkg::beat_t               dat_i,
    input  ev_pkg::phase_t              phase_i,
    input  logic [ev_pkg::WADDR_W-1:0]  waddr_i,
    input  logic                        wr_en_i,
    output ev_pkg::bank_wr_set_t        wr_o
);
    import ev_pkg::*;

    // reordered chunks with chunk 0 from the low 24 bits of the beat
    logic [CHUNKS_PER_BEAT-1:0][CHUNK_W-1:0] chunk;
    // A, B and C holding words
    stored_word_u  hold_q;
    // phase that loaded the holding words
    phase_t        wph_q;
    logic [3:0]    be_a;
    logic [3:0]    be_b;
    logic [3:0]    be_c;

    // output nybble i takes input nybble (letter i - 'A')
    for (genvar c = 0; c < CHUNKS_PER_BEAT; c++) begin : g_chunk
        for (genvar n = 0; n < NYB_PER_CHUNK; n++) begin : g_nyb
            localparam int SRC = int'(SAMPLE_ORDER[8*n +: 8] - ORDER_BASE_CHAR);
            assign chunk[c][4*n +: 4] = dat_i[CHUNK_W*c + 4*SRC +: 4];
        end
    end

    always_ff @(posedge memclk_i) begin
        if (reset_laddr_delay_i) begin
            wph_q <= PHASE_RESET;
        end else begin
            wph_q <= phase_i;
        end
    end

    // phase-steered loads of the holding words
    always_ff @(posedge memclk_i) begin
        // A0..A2 skip phase 2 and still hold chunk2 of the phase 1 beat
        if (!phase_i[2]) begin
            unique case (1'b1)
                phase_i[3]: hold_q.bank[0][23:0] <= chunk[0];
                phase_i[0]: hold_q.bank[0][23:0] <= chunk[1];
                default:    hold_q.bank[0][23:0] <= chunk[2];
            endcase
        end
        // A3 and B0..B1 mix lanes and take the muxed value in phases 0 and 2
        if (phase_i[0]) begin
            hold_q.bank[0][31:24] <= chunk[2][7:0];
            hold_q.bank[1][15:0]  <= chunk[2][23:8];
        end else if (phase_i[2]) begin
            hold_q.bank[0][31:24] <= chunk[0][7:0];
            hold_q.bank[1][15:0]  <= chunk[0][23:8];
        end else begin
            hold_q.bank[0][31:24] <= chunk[1][7:0];
            hold_q.bank[1][15:0]  <= chunk[1][23:8];
        end
        // B2..B3 and C0 travel together
        if (phase_i[1]) begin
            hold_q.bank[1][31:16] <= chunk[0][15:0];
            hold_q.bank[2][7:0]   <= chunk[0][23:16];
        end else if (phase_i[2]) begin
            hold_q.bank[1][31:16] <= chunk[1][15:0];
            hold_q.bank[2][7:0]   <= chunk[1][23:16];
        end else begin
            hold_q.bank[1][31:16] <= chunk[2][15:0];
            hold_q.bank[2][7:0]   <= chunk[2][23:16];
        end
        // C1..C3 take a whole chunk
        unique case (1'b1)
            phase_i[0]: hold_q.bank[2][31:8] <= chunk[0];
            phase_i[1]: hold_q.bank[2][31:8] <= chunk[1];
            default:    hold_q.bank[2][31:8] <= chunk[2];
        endcase
    end

    // byte enables follow the loading phase and stay low while not writing
    always_comb begin
        be_a = {4{~wph_q[1]}};
        be_b = {{2{~wph_q[0]}}, {2{~wph_q[1]}}};
        be_c = {{3{~wph_q[3]}}, ~wph_q[0]};
        if (!wr_en_i) begin
            be_a = '0;
            be_b = '0;
            be_c = '0;
        end
    end

    always_comb begin
        wr_o.a.addr    = waddr_i;
        wr_o.a.be      = be_a;
        wr_o.a.addr_en = 1'b1;
        wr_o.a.data    = hold_q.bank[0];
        wr_o.b.addr    = waddr_i;
        wr_o.b.be      = be_b;
        wr_o.b.addr_en = 1'b1;
        wr_o.b.data    = hold_q.bank[1];
        // C finishes the previous word in phase 0
        wr_o.c.addr    = waddr_i;
        wr_o.c.be      = be_c;
        wr_o.c.addr_en = ~wph_q[0];
        wr_o.c.data    = hold_q.bank[2];
    end

    // phase 0 writes bank C at the word address latched by the write just before
    a_c_addr_latched : assert property (
        @(posedge memclk_i) disable iff (reset_laddr_delay_i)
        (wr_en_i && wph_q[0]) |-> $past(wr_en_i)
    );

endmodule

/* hw/ev_write_sequencer.sv */
`timescale 1ns/1ps
module ev_write_sequencer #(
    parameter int RUN_DELAY = 0
) (
    input  logic                        memclk_i,
    input  logic                        reset_laddr_delay_i,
    input  logic                        channel_run_i,
    input  logic [ev_pkg::UADDR_W-1:0]  bram_uaddr_i,
    output ev_pkg::phase_t              phase_o,
    output logic [ev_pkg::WADDR_W-1:0]  waddr_o,
    output logic                        wr_en_o,
    output logic [ev_pkg::UADDR_W-1:0]  uaddr_o
);
    import ev_pkg::*;

    // run level after the programmable delay
    logic                run_d;
    logic                run_prev_q;
    logic                start;
    // lower address clears off the start pulse
    logic                reset_laddr;
    phase_t              phase_q;
    logic [WADDR_W-1:0]  lcnt_q;
    logic [UADDR_W-1:0]  uaddr_q;
    logic                wr_en_q;

    // delay line for the run level
    generate
        if (RUN_DELAY == 0) begin : g_no_delay
            assign run_d = channel_run_i;
        end else begin : g_delay
            logic [RUN_DELAY-1:0] run_sr_q;

            always_ff @(posedge memclk_i) begin
                if (reset_laddr_delay_i) begin
                    run_sr_q <= '0;
                end else begin
                    run_sr_q <= RUN_DELAY'({run_sr_q, channel_run_i});
                end
            end
            assign run_d = run_sr_q[RUN_DELAY-1];
        end
    endgenerate

    // rising edge of the delayed run
    assign start = run_d & ~run_prev_q;
    assign reset_laddr = start;

    // the beat sampled with start already sees phase 3
    assign phase_o = start ? PHASE_RESET : phase_q;

    always_ff @(posedge memclk_i) begin
        if (reset_laddr_delay_i) begin
            run_prev_q <= 1'b0;
            phase_q    <= PHASE_RESET;
            lcnt_q     <= '0;
            uaddr_q    <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            run_prev_q <= run_d;
            // one-hot rotation from 3 through 0, 1 and 2
            phase_q <= {phase_o[2:0], phase_o[3]};
            // three words per four beats so the count holds once in phase 1
            if (reset_laddr) begin
                lcnt_q <= '0;
            end else if (!phase_o[1]) begin
                lcnt_q <= lcnt_q + 1'b1;
            end
            // upper address only taken at the start of a burst
            if (start) begin
                uaddr_q <= bram_uaddr_i;
            end
            // second stage behind the delayed run lines up with the holding words
            wr_en_q <= run_d;
        end
    end

    // word address of the holding words being written this cycle
    assign waddr_o = {uaddr_q, {LADDR_W{1'b0}}} + lcnt_q;
    assign wr_en_o = wr_en_q;
    assign uaddr_o = uaddr_q;

    // a burst ends after a whole number of 4-beat groups
    a_whole_groups : assert property (
        @(posedge memclk_i) disable iff (reset_laddr_delay_i)
        $fell(run_d) |-> (phase_q == PHASE_RESET)
    );

endmodule

/* hw/ev_pkg.sv */
package ev_pkg;

    // one input beat is six 12-bit samples
    localparam int BEAT_W = 72;
    localparam int SAMPLE_W = 12;
    // a beat splits into three 24-bit chunks of six nybbles each
    localparam int CHUNK_W = 24;
    localparam int CHUNKS_PER_BEAT = 3;
    localparam int NYB_PER_CHUNK = 6;

    // three 32-bit banks, A B and C, make up one 96-bit stored word
    localparam int BANK_W = 32;
    localparam int NUM_BANKS = 3;
    localparam int BYTES_PER_BANK = 4;
    localparam int BYTES_PER_WORD = 12;

    // upper address comes from outside, lower address is generated here
    localparam int UADDR_W = 8;
    localparam int LADDR_W = 2;
    localparam int WADDR_W = UADDR_W + LADDR_W;
    // read side addresses single bytes inside a bank
    localparam int RADDR_W = WADDR_W + 2;

    // sample order letters count up from 'A'
    localparam logic [7:0] ORDER_BASE_CHAR = 8'h41;
    // straight capture, readout bytes come out as BA, DC, FE
    localparam logic [8*NYB_PER_CHUNK-1:0] DEF_SAMPLE_ORDER = "FEDCBA";

    typedef logic [BEAT_W-1:0] beat_t;

    // one-hot write phase, bit n is phase n
    typedef logic [3:0] phase_t;
    localparam phase_t PHASE_0 = 4'b0001;
    localparam phase_t PHASE_1 = 4'b0010;
    localparam phase_t PHASE_2 = 4'b0100;
    localparam phase_t PHASE_3 = 4'b1000;
    // phase 3 is where a fresh burst begins
    localparam phase_t PHASE_RESET = PHASE_3;

    // write into one bank
    typedef struct packed {
        logic [WADDR_W-1:0] addr;
        logic [3:0]         be;
        // low means the bank keeps the address it last latched
        logic               addr_en;
        logic [BANK_W-1:0]  data;
    } bank_wr_t;

    typedef struct packed {
        bank_wr_t c;
        bank_wr_t b;
        bank_wr_t a;
    } bank_wr_set_t;

    // read request, one bank bit at most
    typedef struct packed {
        logic [NUM_BANKS-1:0] sel;
        logic [RADDR_W-1:0]   raddr;
    } rd_req_t;

    // one stored word, seen as bank words on the write side
    // and as a byte stream on the read side
    typedef union packed {
        logic [NUM_BANKS-1:0][BANK_W-1:0]     bank;
        logic [BYTES_PER_WORD-1:0][7:0]       bytes;
    } stored_word_u;

endpackage
